/* compile.f */
+incdir+include
hdl/dly_ctrl_pkg.sv
hdl/dly_path_pkg.sv
hdl/dly_cmd_decode.sv
hdl/dly_lane.sv
hdl/dly_bank.sv
hdl/dly_readback.sv
hdl/dly_ctrl_top.sv
verification/dly_ctrl_chk.sv
verification/dly_ctrl_tb.sv

/* Makefile */
# Verilator flow for the delay-line controller
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= dly_ctrl_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/dly_ctrl_tb.sv */
// Delay-line controller testbench
// table-driven tap commands with readback checks, plus a reference
// history model that predicts every bit of the delayed data

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_ctrl_tb;

    localparam int CLK_HALF      = 20;
    localparam int EDGE_TIMEOUT  = 8 * CLK_HALF;   // ns, four clock periods
    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 200;
    localparam int NUM_STEPS     = 19;

    // one table row: command fields and the tap expected on readback
    typedef struct packed {
        dly_ctrl_pkg::dly_sel_t sel;
        logic                   ld;
        logic                   adj;
        logic                   incdec;
        dly_path_pkg::dly_tap_t tap;
        dly_path_pkg::dly_tap_t exp_tap;
    } step_t;

    logic                     clk_i_buf;
    logic                     reset_buf;
    dly_ctrl_pkg::dly_cmd_t   cmd;
    dly_path_pkg::bank_data_t din_idly;
    dly_path_pkg::bank_data_t din_odly;
    dly_path_pkg::dly_data_t  data_delayed;
    dly_path_pkg::dly_tap_t   dly_tap_val;

    step_t                  steps [NUM_STEPS];
    logic [`DLY_TAP_MAX:0]  hist_model [`DLY_NUM_DLY];  // indexed like sel
    dly_path_pkg::dly_tap_t tap_model [`DLY_NUM_DLY];
    integer                 seed;
    int                     error_count;
    bit                     edge_seen;

    dly_ctrl_top i_dly_ctrl_top (
        .clk_i_buf    (clk_i_buf),
        .reset_buf    (reset_buf),
        .cmd          (cmd),
        .din_idly     (din_idly),
        .din_odly     (din_odly),
        .data_delayed (data_delayed),
        .dly_tap_val  (dly_tap_val)
    );

    initial clk_i_buf = 1'b0;
    always #(CLK_HALF) clk_i_buf = ~clk_i_buf;

    //************************************************************
    // failure handling and compare tasks
    //************************************************************
    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_tap(input dly_path_pkg::dly_tap_t got,
                             input dly_path_pkg::dly_tap_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED dly_tap_val exp=%h got=%h", exp, got);
            error_count++;
            stop_run();
        end
    endtask

    task automatic check_data(input dly_path_pkg::dly_data_t got,
                              input dly_path_pkg::dly_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED data_delayed exp=%h got=%h", exp, got);
            error_count++;
            stop_run();
        end
    endtask

    //************************************************************
    // clocking, data stimulus and reference model
    //************************************************************
    task automatic next_fall();
        edge_seen = 1'b0;
        fork
            begin
                @(negedge clk_i_buf);
                edge_seen = 1'b1;
            end
            #(EDGE_TIMEOUT);
        join_any
        if (!edge_seen) begin
            $display("timed out waiting for a falling clock edge");
            stop_run();
        end
    endtask

    // lane k is fed by input bank bit k/2 when k is even, output bank otherwise
    task automatic shift_model();
        logic d;
        for (int k = 0; k < `DLY_NUM_DLY; k++) begin
            d = (k % 2 == 1) ? din_odly[k/2] : din_idly[k/2];
            if (!reset_buf) begin
                hist_model[k] = '0;
            end else begin
                hist_model[k] = {hist_model[k][`DLY_TAP_MAX-1:0], d};
            end
        end
    endtask

    task automatic drive_data();
        logic [31:0] rnd;
        rnd      = $random(seed);
        din_idly = rnd[`DLY_LANES_PER_BANK-1:0];
        rnd      = $random(seed);
        din_odly = rnd[`DLY_LANES_PER_BANK-1:0];
    endtask

    // each cycle: falling edge, record what the rising edge sampled, new data
    task automatic wait_cycles(input int n);
        for (int c = 0; c < n; c++) begin
            next_fall();
            shift_model();
            drive_data();
        end
    endtask

    function automatic dly_path_pkg::dly_data_t predict_data();
        dly_path_pkg::dly_data_t p;
        p = '0;
        for (int k = 0; k < `DLY_NUM_DLY; k++) begin
            p[k] = hist_model[k][tap_model[k]];
        end
        return p;
    endfunction

    //************************************************************
    // command table
    //************************************************************
    task automatic load_table();
        steps[0]  = '{2'd0, 1'b1, 1'b0, 1'b0, 6'd5,  6'd5};   // loads on all lanes
        steps[1]  = '{2'd1, 1'b1, 1'b0, 1'b0, 6'd17, 6'd17};
        steps[2]  = '{2'd2, 1'b1, 1'b0, 1'b0, 6'd12, 6'd12};
        steps[3]  = '{2'd3, 1'b1, 1'b0, 1'b0, 6'd42, 6'd42};
        steps[4]  = '{2'd0, 1'b0, 1'b0, 1'b0, 6'd0,  6'd5};   // plain reads
        steps[5]  = '{2'd2, 1'b0, 1'b0, 1'b0, 6'd0,  6'd12};
        steps[6]  = '{2'd3, 1'b0, 1'b1, 1'b1, 6'd0,  6'd43};
        steps[7]  = '{2'd3, 1'b0, 1'b1, 1'b0, 6'd0,  6'd42};
        steps[8]  = '{2'd2, 1'b1, 1'b0, 1'b0, 6'd1,  6'd1};
        steps[9]  = '{2'd2, 1'b0, 1'b1, 1'b0, 6'd0,  6'd0};
        steps[10] = '{2'd2, 1'b0, 1'b1, 1'b0, 6'd0,  6'd0};   // floor at 0
        steps[11] = '{2'd1, 1'b1, 1'b0, 1'b0, 6'd63, 6'd63};
        steps[12] = '{2'd1, 1'b0, 1'b1, 1'b1, 6'd0,  6'd63};  // ceiling at 63
        steps[13] = '{2'd1, 1'b0, 1'b1, 1'b0, 6'd0,  6'd62};
        steps[14] = '{2'd0, 1'b1, 1'b1, 1'b1, 6'd9,  6'd9};   // load beats adjust
        steps[15] = '{2'd3, 1'b1, 1'b1, 1'b0, 6'd20, 6'd20};
        steps[16] = '{2'd1, 1'b0, 1'b0, 1'b0, 6'd0,  6'd62};
        steps[17] = '{2'd0, 1'b0, 1'b1, 1'b0, 6'd0,  6'd8};
        steps[18] = '{2'd2, 1'b0, 1'b0, 1'b0, 6'd0,  6'd0};
    endtask

    // one command cycle, two idle cycles on the same lane, then compare
    task automatic apply_step(input step_t s);
        cmd.sel    = s.sel;
        cmd.ld     = s.ld;
        cmd.adj    = s.adj;
        cmd.incdec = s.incdec;
        cmd.tap    = s.tap;
        wait_cycles(1);
        cmd.ld     = 1'b0;
        cmd.adj    = 1'b0;
        cmd.incdec = 1'b0;
        cmd.tap    = '0;
        wait_cycles(2);
        if (int'(s.sel) < `DLY_NUM_DLY) begin
            tap_model[s.sel] = s.exp_tap;
        end
        check_tap(dly_tap_val, s.exp_tap);
        check_data(data_delayed, predict_data());
    endtask

    //************************************************************
    // main sequence
    //************************************************************
    initial begin
        seed        = 32'h6301_1665;
        error_count = 0;
        reset_buf   = 1'b0;
        cmd         = '0;
        din_idly    = '0;
        din_odly    = '0;
        for (int k = 0; k < `DLY_NUM_DLY; k++) begin
            hist_model[k] = '0;
            tap_model[k]  = '0;
        end
        load_table();

        wait_cycles(RESET_CYCLES);          // random data already running
        check_tap(dly_tap_val, '0);
        check_data(data_delayed, '0);
        reset_buf = 1'b1;

        for (int e = 0; e < NUM_STEPS; e++) begin
            apply_step(steps[e]);
        end

        // only reachable when the select is wider than the lane count
        if (`DLY_NUM_DLY < (1 << `DLY_SEL_WIDTH)) begin
            apply_step('{dly_ctrl_pkg::dly_sel_t'(`DLY_NUM_DLY), 1'b1, 1'b0, 1'b0,
                         6'd7, 6'd0});
        end

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            wait_cycles(1);
            check_data(data_delayed, predict_data());
        end

        if (error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* verification/dly_ctrl_chk.sv */
// Delay controller port checker
// bound to the top level, watches reset clearing and tap readback

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_ctrl_chk (
    input logic                    clk_i_buf,
    input logic                    reset_buf,
    input dly_ctrl_pkg::dly_cmd_t  cmd,
    input dly_path_pkg::dly_data_t data_delayed,
    input dly_path_pkg::dly_tap_t  dly_tap_val
);

    //************************************************************
    // reset clears both outputs one cycle later
    //************************************************************
    a_reset_clear: assert property (@(posedge clk_i_buf)
        !reset_buf |=> (dly_tap_val == '0) && (data_delayed == '0))
        else $error("outputs not cleared after a reset cycle");

    // readback of cycle t+1 depends on the command sampled at t-2
    a_tap_hold: assert property (@(posedge clk_i_buf)
        ($past(reset_buf, 1) && $past(reset_buf, 2)
         && ($past(cmd.sel, 1) == $past(cmd.sel, 2))
         && !$past(cmd.ld, 3) && !$past(cmd.adj, 3))
        |-> $stable(dly_tap_val))
        else $error("tap readback moved without a command");

    // readback moves by at most one without a load
    a_tap_step: assert property (@(posedge clk_i_buf)
        ($past(reset_buf, 1) && $past(reset_buf, 2)
         && ($past(cmd.sel, 1) == $past(cmd.sel, 2))
         && !$past(cmd.ld, 3))
        |-> ((int'(dly_tap_val) - int'($past(dly_tap_val))) inside {-1, 0, 1}))
        else $error("tap readback stepped by more than one");

endmodule

bind dly_ctrl_top dly_ctrl_chk i_dly_ctrl_chk (
    .clk_i_buf    (clk_i_buf),
    .reset_buf    (reset_buf),
    .cmd          (cmd),
    .data_delayed (data_delayed),
    .dly_tap_val  (dly_tap_val)
);

/* hdl/dly_ctrl_top.sv */
// Programmable delay-line controller
// command decode feeding an input and an output delay bank,
// with interleaved data out and tap readback

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_ctrl_top (
    input  logic                     clk_i_buf,
    input  logic                     reset_buf,
    input  dly_ctrl_pkg::dly_cmd_t   cmd,
    input  dly_path_pkg::bank_data_t din_idly,
    input  dly_path_pkg::bank_data_t din_odly,
    output dly_path_pkg::dly_data_t  data_delayed,
    output dly_path_pkg::dly_tap_t   dly_tap_val
);

    dly_ctrl_pkg::bank_ctrl_t idly_ctrl;
    dly_ctrl_pkg::bank_ctrl_t odly_ctrl;
    dly_path_pkg::dly_tap_t   load_tap;
    dly_path_pkg::bank_data_t idly_dout;
    dly_path_pkg::bank_data_t odly_dout;
    dly_path_pkg::bank_tap_t  idly_taps;
    dly_path_pkg::bank_tap_t  odly_taps;

    dly_cmd_decode i_dly_cmd_decode (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .cmd       (cmd),
        .idly_ctrl (idly_ctrl),
        .odly_ctrl (odly_ctrl),
        .load_tap  (load_tap)
    );

    //**********************************************************
    // input and output delay banks
    //**********************************************************
    dly_bank #(.NUM_LANES(`DLY_LANES_PER_BANK)) i_idly_bank (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .ctrl      (idly_ctrl),
        .load_tap  (load_tap),
        .din       (din_idly),
        .dout      (idly_dout),
        .taps      (idly_taps)
    );

    dly_bank #(.NUM_LANES(`DLY_LANES_PER_BANK)) i_odly_bank (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .ctrl      (odly_ctrl),
        .load_tap  (load_tap),
        .din       (din_odly),
        .dout      (odly_dout),
        .taps      (odly_taps)
    );

    dly_readback i_dly_readback (
        .clk_i_buf    (clk_i_buf),
        .reset_buf    (reset_buf),
        .sel          (cmd.sel),    // live select, not the registered one
        .idly_dout    (idly_dout),
        .odly_dout    (odly_dout),
        .idly_taps    (idly_taps),
        .odly_taps    (odly_taps),
        .data_delayed (data_delayed),
        .dly_tap_val  (dly_tap_val)
    );

endmodule

/* hdl/dly_readback.sv */
// Delay readback and output merge
// interleaves the two banks onto the data output and registers
// the tap of the lane picked by the command select

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_readback (
    input  logic                     clk_i_buf,
    input  logic                     reset_buf,
    input  dly_ctrl_pkg::dly_sel_t   sel,
    input  dly_path_pkg::bank_data_t idly_dout,
    input  dly_path_pkg::bank_data_t odly_dout,
    input  dly_path_pkg::bank_tap_t  idly_taps,
    input  dly_path_pkg::bank_tap_t  odly_taps,
    output dly_path_pkg::dly_data_t  data_delayed,
    output dly_path_pkg::dly_tap_t   dly_tap_val
);

    logic [`DLY_SEL_WIDTH-2:0] lane_idx;

    assign lane_idx = sel[`DLY_SEL_WIDTH-1:1];

    //**********************************************************
    // data interleave, even bits input lanes, odd bits output
    //**********************************************************
    always_comb begin
        for (int i = 0; i < `DLY_LANES_PER_BANK; i++) begin
            data_delayed[2*i]   = idly_dout[i];
            data_delayed[2*i+1] = odly_dout[i];
        end
    end

    // tap readback register
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            dly_tap_val <= '0;
        end else if (sel >= `DLY_NUM_DLY) begin
            dly_tap_val <= '0;              // no such lane
        end else if (sel[0]) begin
            dly_tap_val <= odly_taps[lane_idx];
        end else begin
            dly_tap_val <= idly_taps[lane_idx];
        end
    end

endmodule

/* hdl/dly_bank.sv */
// Delay lane bank
// a row of identical lanes serving one direction, sharing
// the load value and taking per-lane strobes

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_bank #(
    parameter int NUM_LANES = `DLY_LANES_PER_BANK
) (
    input  logic                                      clk_i_buf,
    input  logic                                      reset_buf,
    input  dly_ctrl_pkg::lane_ctrl_t [NUM_LANES-1:0]  ctrl,
    input  dly_path_pkg::dly_tap_t                    load_tap,
    input  logic [NUM_LANES-1:0]                      din,
    output logic [NUM_LANES-1:0]                      dout,
    output dly_path_pkg::dly_tap_t   [NUM_LANES-1:0]  taps
);

    //**********************************************************
    // lanes
    //**********************************************************
    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i = i + 1) begin : g_lane
            dly_lane i_dly_lane (
                .clk_i_buf (clk_i_buf),
                .reset_buf (reset_buf),
                .ctrl      (ctrl[i]),
                .load_tap  (load_tap),  // only the strobed lane uses it
                .din       (din[i]),
                .dout      (dout[i]),
                .tap       (taps[i])
            );
        end
    endgenerate

endmodule

/* hdl/dly_lane.sv */
// Single delay lane
// saturating tap counter plus a shift history of the data bit,
// output is the history entry picked by the tap

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_lane (
    input  logic                      clk_i_buf,
    input  logic                      reset_buf,
    input  dly_ctrl_pkg::lane_ctrl_t  ctrl,
    input  dly_path_pkg::dly_tap_t    load_tap,
    input  logic                      din,
    output logic                      dout,
    output dly_path_pkg::dly_tap_t    tap
);

    logic [`DLY_TAP_MAX:0] hist;     // entry 0 is the newest sample
    logic                  at_max;
    logic                  at_min;

    assign at_max = (tap == dly_path_pkg::dly_tap_t'(`DLY_TAP_MAX));
    assign at_min = (tap == '0);

    //**********************************************************
    // tap counter
    //**********************************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            tap <= '0;
        end else if (ctrl.ld) begin
            tap <= load_tap;                // load beats adjust
        end else if (ctrl.adj) begin
            if (ctrl.incdec && !at_max) begin
                tap <= tap + 1'b1;
            end else if (!ctrl.incdec && !at_min) begin
                tap <= tap - 1'b1;
            end
        end
    end

    // data history, one shift per clock
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            hist <= '0;
        end else begin
            hist <= {hist[`DLY_TAP_MAX-1:0], din};
        end
    end

    // tap 0 gives the bit from the latest edge
    assign dout = hist[tap];

endmodule

/* hdl/dly_cmd_decode.sv */
// Delay command decoder
// registers the user command and steers its strobes to the one
// selected lane of the input or output bank

`timescale 1ns/1ps

`include "dly_defs.svh"

module dly_cmd_decode (
    input  logic                    clk_i_buf,
    input  logic                    reset_buf,
    input  dly_ctrl_pkg::dly_cmd_t  cmd,
    output dly_ctrl_pkg::bank_ctrl_t idly_ctrl,
    output dly_ctrl_pkg::bank_ctrl_t odly_ctrl,
    output dly_path_pkg::dly_tap_t  load_tap
);

    dly_ctrl_pkg::dly_cmd_t   cmd_q;
    dly_ctrl_pkg::lane_ctrl_t sel_ctrl;
    logic [`DLY_SEL_WIDTH-2:0] lane_idx;
    logic                     sel_valid;

    //**********************************************************
    // command register
    //**********************************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            cmd_q <= '0;
        end else begin
            cmd_q <= cmd;
        end
    end

    assign lane_idx  = cmd_q.sel[`DLY_SEL_WIDTH-1:1];  // upper bits pick the lane
    assign sel_valid = (cmd_q.sel < `DLY_NUM_DLY);
    assign load_tap  = cmd_q.tap;

    always_comb begin
        sel_ctrl.ld     = cmd_q.ld;
        sel_ctrl.adj    = cmd_q.adj;
        sel_ctrl.incdec = cmd_q.incdec;
    end

    //**********************************************************
    // one-hot lane steering
    //**********************************************************
    always_comb begin
        idly_ctrl = '0;
        odly_ctrl = '0;
        if (sel_valid) begin
            if (cmd_q.sel[0]) begin         // odd select is an output lane
                odly_ctrl[lane_idx] = sel_ctrl;
            end else begin
                idly_ctrl[lane_idx] = sel_ctrl;
            end
        end
    end

endmodule

/* hdl/dly_path_pkg.sv */
// Delay-line data path types
// tap values and the lane data vectors

`include "dly_defs.svh"

package dly_path_pkg;

    // tap of one lane, also the delay in clocks
    typedef logic [`DLY_TAP_WIDTH-1:0] dly_tap_t;

    // taps of all lanes in one bank
    typedef dly_tap_t [`DLY_LANES_PER_BANK-1:0] bank_tap_t;

    // one bit per lane of a bank
    typedef logic [`DLY_LANES_PER_BANK-1:0] bank_data_t;

    // top level data, input and output lanes interleaved
    typedef logic [`DLY_NUM_DLY-1:0] dly_data_t;

endpackage

/* hdl/dly_ctrl_pkg.sv */
// Delay-line control types
// user command word and the per-lane strobe bundles

`include "dly_defs.svh"

package dly_ctrl_pkg;

    // even index -> input lane sel/2, odd index -> output lane (sel-1)/2
    typedef logic [`DLY_SEL_WIDTH-1:0] dly_sel_t;

    // one command, sampled every cycle with no handshake
    typedef struct packed {
        dly_sel_t                   sel;
        logic                       ld;     // load tap
        logic                       adj;    // step tap by one
        logic                       incdec; // 1 up, 0 down
        logic [`DLY_TAP_WIDTH-1:0]  tap;    // load value
    } dly_cmd_t;

    // strobes seen by a single lane
    typedef struct packed {
        logic ld;
        logic adj;
        logic incdec;
    } lane_ctrl_t;

    // one entry per lane of a bank
    typedef lane_ctrl_t [`DLY_LANES_PER_BANK-1:0] bank_ctrl_t;

endpackage

/* include/dly_defs.svh */
// Delay-line controller sizing
// lane count, tap width and select width shared by all blocks

`ifndef DLY_DEFS_SVH
`define DLY_DEFS_SVH

// total lanes, half input delays and half output delays (keep it even)
`define DLY_NUM_DLY         4

// tap counter width, sets the history depth too
`define DLY_TAP_WIDTH       6

// lane index width on the command port
`define DLY_SEL_WIDTH       2

// lanes in one direction
`define DLY_LANES_PER_BANK  (`DLY_NUM_DLY / 2)

// highest tap, 63 for a 6 bit tap
`define DLY_TAP_MAX         ((1 << `DLY_TAP_WIDTH) - 1)

`endif
